// ==== hw/video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

	// scan positions and counters share one width.
	localparam int COORD_W = 11;

	typedef logic [COORD_W-1:0] coord_t;

	// small default raster counted in pixel clocks.
	localparam int DEF_H_ACTIVE = 16;
	localparam int DEF_H_FRONT  = 2;
	localparam int DEF_H_PULSE  = 3;
	localparam int DEF_H_BACK   = 3;

	// vertical values are counted in lines.
	localparam int DEF_V_ACTIVE = 8;
	localparam int DEF_V_FRONT  = 1;
	localparam int DEF_V_PULSE  = 2;
	localparam int DEF_V_BACK   = 2;

	// 0 is negative sync, 1 is positive sync.
	localparam int DEF_SYNC_POL = 0;

endpackage

`default_nettype wire

// ==== hw/video_pixel_pkg.sv ====
`default_nettype none

package video_pixel_pkg;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef enum logic [1:0] {
		PAT_BARS    = 2'd0, // eight colour bars.
		PAT_CHECKER = 2'd1,
		PAT_RAMP    = 2'd2, // grey ramp along x.
		PAT_SOLID   = 2'd3
	} pattern_mode_t;

	localparam int BAR_COUNT   = 8;
	localparam int CHECK_SHIFT = 2; // 4 by 4 pixel cells.
	localparam int RAMP_SHIFT  = 4;

	localparam rgb_t RGB_BLACK = '{red: 8'h00, green: 8'h00, blue: 8'h00};
	localparam rgb_t RGB_WHITE = '{red: 8'hff, green: 8'hff, blue: 8'hff};

endpackage

`default_nettype wire

// ==== hw/video_sync_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface video_sync_if
	import video_timing_pkg::*;
();

	logic   hsync_act;   // high inside the horizontal pulse.
	logic   vsync_act;   // high inside the vertical pulse.
	logic   active;      // data enable.
	coord_t pos_x;
	coord_t pos_y;
	logic   frame_start; // one cycle at the top of the frame.

	modport source (
		output hsync_act,
		output vsync_act,
		output active,
		output pos_x,
		output pos_y,
		output frame_start
	);

	modport sink (
		input hsync_act,
		input vsync_act,
		input active,
		input pos_x,
		input pos_y,
		input frame_start
	);

endinterface

`default_nettype wire

// ==== hw/video_timing_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing_gen
	import video_timing_pkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int H_FRONT  = DEF_H_FRONT,
	parameter int H_PULSE  = DEF_H_PULSE,
	parameter int H_BACK   = DEF_H_BACK,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int V_FRONT  = DEF_V_FRONT,
	parameter int V_PULSE  = DEF_V_PULSE,
	parameter int V_BACK   = DEF_V_BACK
) (
	input  wire                 i_clock_out,
	input  wire                 i_rst,
	video_sync_if.source        o_sync
);

	// a line runs back porch, active, front porch, then sync.
	localparam int H_TOTAL = H_BACK + H_ACTIVE + H_FRONT + H_PULSE;
	localparam int V_TOTAL = V_BACK + V_ACTIVE + V_FRONT + V_PULSE;

	localparam coord_t H_LAST       = coord_t'(H_TOTAL - 1);
	localparam coord_t H_ACT_START  = coord_t'(H_BACK);
	localparam coord_t H_ACT_END    = coord_t'(H_BACK + H_ACTIVE);
	localparam coord_t H_SYNC_START = coord_t'(H_TOTAL - H_PULSE);

	localparam coord_t V_LAST       = coord_t'(V_TOTAL - 1);
	localparam coord_t V_ACT_START  = coord_t'(V_BACK);
	localparam coord_t V_ACT_END    = coord_t'(V_BACK + V_ACTIVE);
	localparam coord_t V_SYNC_START = coord_t'(V_TOTAL - V_PULSE);

	coord_t h_cnt;
	coord_t v_cnt;

	logic h_in_active;
	logic v_in_active;
	logic h_in_sync;
	logic v_in_sync;
	logic at_frame_top;

	// free running raster counters.
	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0; // end of line.
			if (v_cnt == V_LAST) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// region decode from the current counts.
	always_comb begin
		h_in_active  = (h_cnt >= H_ACT_START) && (h_cnt < H_ACT_END);
		v_in_active  = (v_cnt >= V_ACT_START) && (v_cnt < V_ACT_END);
		h_in_sync    = (h_cnt >= H_SYNC_START);
		v_in_sync    = (v_cnt >= V_SYNC_START); // whole lines.
		at_frame_top = (h_cnt == '0) && (v_cnt == '0);
	end

	// one register stage for the levels and the frame pulse.
	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			o_sync.hsync_act   <= 1'b0;
			o_sync.vsync_act   <= 1'b0;
			o_sync.active      <= 1'b0;
			o_sync.frame_start <= 1'b0;
		end else begin
			o_sync.hsync_act   <= h_in_sync;
			o_sync.vsync_act   <= v_in_sync;
			o_sync.active      <= h_in_active && v_in_active;
			o_sync.frame_start <= at_frame_top;
		end
	end

	// positions are relative to the end of the back porch.
	always_ff @(posedge i_clock_out) begin
		o_sync.pos_x <= h_cnt - H_ACT_START;
		o_sync.pos_y <= v_cnt - V_ACT_START;
	end

endmodule

`default_nettype wire

// ==== hw/video_pattern_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_pattern_gen
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE
) (
	input  wire                 i_clock_out,
	input  wire                 i_rst,
	input  pattern_mode_t       i_mode,
	input  rgb_t                i_solid_color,
	video_sync_if.sink          i_sync,
	video_sync_if.source        o_sync,
	output rgb_t                o_pixel
);

	localparam int BAR_W = H_ACTIVE / BAR_COUNT;

	pattern_mode_t mode_q;
	rgb_t          solid_q;

	coord_t bar_idx;
	coord_t ramp_x;
	logic   check_odd;
	rgb_t   pixel_next;

	// mode and colour only change at the top of a frame.
	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			mode_q <= PAT_BARS;
		end else if (i_sync.frame_start) begin
			mode_q <= i_mode;
		end
	end

	always_ff @(posedge i_clock_out) begin
		if (i_sync.frame_start) begin
			solid_q <= i_solid_color;
		end
	end

	always_comb begin
		bar_idx   = i_sync.pos_x / coord_t'(BAR_W);
		ramp_x    = i_sync.pos_x << RAMP_SHIFT;
		check_odd = i_sync.pos_x[CHECK_SHIFT] ^ i_sync.pos_y[CHECK_SHIFT];

		case (mode_q)
			PAT_BARS: begin
				pixel_next.red   = {8{bar_idx[2]}};
				pixel_next.green = {8{bar_idx[1]}};
				pixel_next.blue  = {8{bar_idx[0]}};
			end
			PAT_CHECKER: pixel_next = check_odd ? RGB_WHITE : RGB_BLACK;
			PAT_RAMP: begin
				pixel_next.red   = ramp_x[7:0]; // same level on all channels.
				pixel_next.green = ramp_x[7:0];
				pixel_next.blue  = ramp_x[7:0];
			end
			PAT_SOLID: pixel_next = solid_q;
			default: pixel_next = RGB_BLACK;
		endcase
	end

	// sync levels travel with the pixel so both stay aligned.
	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			o_sync.hsync_act   <= 1'b0;
			o_sync.vsync_act   <= 1'b0;
			o_sync.active      <= 1'b0;
			o_sync.frame_start <= 1'b0;
		end else begin
			o_sync.hsync_act   <= i_sync.hsync_act;
			o_sync.vsync_act   <= i_sync.vsync_act;
			o_sync.active      <= i_sync.active;
			o_sync.frame_start <= i_sync.frame_start;
		end
	end

	always_ff @(posedge i_clock_out) begin
		o_sync.pos_x <= i_sync.pos_x;
		o_sync.pos_y <= i_sync.pos_y;
		o_pixel      <= pixel_next;
	end

endmodule

`default_nettype wire

// ==== hw/video_output_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_output_stage
	import video_pixel_pkg::*;
#(
	parameter int SYNC_POL = 0
) (
	input  wire                 i_clock_out,
	input  wire                 i_rst,
	video_sync_if.sink          i_sync,
	input  rgb_t                i_pixel,
	output logic                o_hsync,
	output logic                o_vsync,
	output logic                o_de,
	output logic                o_frame_start,
	output rgb_t                o_pixel
);

	// level driven during a pulse.
	localparam logic PULSE_LVL = 1'(SYNC_POL);

	logic hsync_pin;
	logic vsync_pin;
	rgb_t pixel_blanked;

	always_comb begin
		hsync_pin     = i_sync.hsync_act ? PULSE_LVL : ~PULSE_LVL;
		vsync_pin     = i_sync.vsync_act ? PULSE_LVL : ~PULSE_LVL;
		pixel_blanked = i_sync.active ? i_pixel : RGB_BLACK; // black in blanking.
	end

	// every pin leaves from a register.
	always_ff @(posedge i_clock_out) begin
		if (i_rst) begin
			o_hsync       <= ~PULSE_LVL;
			o_vsync       <= ~PULSE_LVL;
			o_de          <= 1'b0;
			o_frame_start <= 1'b0;
			o_pixel       <= RGB_BLACK;
		end else begin
			o_hsync       <= hsync_pin;
			o_vsync       <= vsync_pin;
			o_de          <= i_sync.active;
			o_frame_start <= i_sync.frame_start;
			o_pixel       <= pixel_blanked;
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_out_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_out_top
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
#(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int H_FRONT  = DEF_H_FRONT,
	parameter int H_PULSE  = DEF_H_PULSE,
	parameter int H_BACK   = DEF_H_BACK,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int V_FRONT  = DEF_V_FRONT,
	parameter int V_PULSE  = DEF_V_PULSE,
	parameter int V_BACK   = DEF_V_BACK,
	parameter int SYNC_POL = DEF_SYNC_POL
) (
	input  wire          i_clock_out,
	input  wire          i_rst,
	input  wire  [1:0]   i_mode,        // pattern_mode_t encoding.
	input  wire  [23:0]  i_solid_color, // red in the top byte.
	output logic         o_hsync,
	output logic         o_vsync,
	output logic         o_de,
	output logic         o_frame_start,
	output logic [7:0]   o_red,
	output logic [7:0]   o_green,
	output logic [7:0]   o_blue
);

	video_sync_if sync_tg ();
	video_sync_if sync_pg ();

	rgb_t pattern_pixel;
	rgb_t out_pixel;

	video_timing_gen #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_PULSE  (H_PULSE),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_PULSE  (V_PULSE),
		.V_BACK   (V_BACK)
	) u_video_timing_gen (
		.i_clock_out (i_clock_out),
		.i_rst       (i_rst),
		.o_sync      (sync_tg.source)
	);

	video_pattern_gen #(
		.H_ACTIVE (H_ACTIVE)
	) u_video_pattern_gen (
		.i_clock_out   (i_clock_out),
		.i_rst         (i_rst),
		.i_mode        (pattern_mode_t'(i_mode)),
		.i_solid_color (rgb_t'(i_solid_color)),
		.i_sync        (sync_tg.sink),
		.o_sync        (sync_pg.source),
		.o_pixel       (pattern_pixel)
	);

	video_output_stage #(
		.SYNC_POL (SYNC_POL)
	) u_video_output_stage (
		.i_clock_out   (i_clock_out),
		.i_rst         (i_rst),
		.i_sync        (sync_pg.sink),
		.i_pixel       (pattern_pixel),
		.o_hsync       (o_hsync),
		.o_vsync       (o_vsync),
		.o_de          (o_de),
		.o_frame_start (o_frame_start),
		.o_pixel       (out_pixel)
	);

	assign o_red   = out_pixel.red;
	assign o_green = out_pixel.green;
	assign o_blue  = out_pixel.blue;

endmodule

`default_nettype wire

// ==== dv/video_out_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_out_tb
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
();

	localparam int CLK_PERIOD_NS = 4;
	localparam int H_TOTAL      = DEF_H_BACK + DEF_H_ACTIVE + DEF_H_FRONT + DEF_H_PULSE;
	localparam int V_TOTAL      = DEF_V_BACK + DEF_V_ACTIVE + DEF_V_FRONT + DEF_V_PULSE;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int TEST_COUNT   = 5;
	localparam int WATCHDOG_NS  = (TEST_COUNT * 4 + 4) * FRAME_CYCLES * CLK_PERIOD_NS;
	localparam logic SYNC_ON    = 1'(DEF_SYNC_POL); // pin level inside a pulse.

	logic        i_clock_out = 1'b0;
	logic        i_rst;
	logic [1:0]  i_mode;
	logic [23:0] i_solid_color;
	logic        o_hsync;
	logic        o_vsync;
	logic        o_de;
	logic        o_frame_start;
	logic [7:0]  o_red;
	logic [7:0]  o_green;
	logic [7:0]  o_blue;

	logic        hs_on;
	logic        vs_on;
	logic        hs_rise;
	logic        hs_fall;
	logic        vs_rise;
	logic        vs_fall;
	logic        de_rise;
	logic        de_fall;
	logic [23:0] pixel;
	logic [23:0] exp_pix;

	logic          hs_prev;
	logic          vs_prev;
	logic          de_prev;
	logic          line_had_de; // this line carried data.
	logic          fs_seen;
	int            h_since_rise;
	int            h_rises;
	int            h_width;
	int            v_since_rise;
	int            v_rises;
	int            v_width;
	int            de_low_cnt;
	int            de_run;
	int            de_lines;
	int            frames_seen;
	int            rst_cnt;
	int            pix_y;
	pattern_mode_t cur_mode;
	logic [23:0]   cur_color;

	int n_hsync;
	int n_vsync;
	int n_front;
	int n_de_line;
	int n_frame_lines;
	int pix_hits [4];

	int          fail_count   = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [31:0] lfsr_state;

	video_out_top u_video_out_top (
		.i_clock_out   (i_clock_out),
		.i_rst         (i_rst),
		.i_mode        (i_mode),
		.i_solid_color (i_solid_color),
		.o_hsync       (o_hsync),
		.o_vsync       (o_vsync),
		.o_de          (o_de),
		.o_frame_start (o_frame_start),
		.o_red         (o_red),
		.o_green       (o_green),
		.o_blue        (o_blue)
	);

	always #(CLK_PERIOD_NS / 2) i_clock_out = ~i_clock_out;

	assign hs_on   = (o_hsync == SYNC_ON);
	assign vs_on   = (o_vsync == SYNC_ON);
	assign hs_rise = hs_on && !hs_prev;
	assign hs_fall = !hs_on && hs_prev;
	assign vs_rise = vs_on && !vs_prev;
	assign vs_fall = !vs_on && vs_prev;
	assign de_rise = o_de && !de_prev;
	assign de_fall = !o_de && de_prev;
	assign pixel   = {o_red, o_green, o_blue};
	assign pix_y   = de_rise ? de_lines : de_lines - 1; // de_run already is x.
	assign exp_pix = expect_pixel(cur_mode, cur_color, de_run, pix_y);

	function automatic logic [23:0] expect_pixel(input pattern_mode_t mode,
			input logic [23:0] color, input int x, input int y);
		int          bar;
		logic [7:0]  lvl;
		logic [23:0] px;
		bar = x / (DEF_H_ACTIVE / BAR_COUNT);
		lvl = 8'(x << RAMP_SHIFT);
		case (mode)
			PAT_BARS:    px = {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
			PAT_CHECKER: px = (((x >> CHECK_SHIFT) & 1) != ((y >> CHECK_SHIFT) & 1)) ?
					24'hffffff : 24'h000000;
			PAT_RAMP:    px = {lvl, lvl, lvl};
			default:     px = color;
		endcase
		return px;
	endfunction

	// fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_color(output logic [23:0] color);
		color = '0;
		for (int i = 0; i < 24; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			color      = {color[22:0], lfsr_state[0]}; // one step per bit.
		end
	endtask

	task automatic value_fail(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		fail_count++;
		$display("[FAIL] %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
	endtask

	// reference state built only from the pins.
	always @(posedge i_clock_out) begin
		if (i_rst) begin
			hs_prev      <= 1'b0;
			vs_prev      <= 1'b0;
			de_prev      <= 1'b0;
			line_had_de  <= 1'b0;
			fs_seen      <= 1'b0;
			h_since_rise <= 0;
			h_rises      <= 0;
			h_width      <= 0;
			v_since_rise <= 0;
			v_rises      <= 0;
			v_width      <= 0;
			de_low_cnt   <= 0;
			de_run       <= 0;
			de_lines     <= 0;
			frames_seen  <= 0;
			rst_cnt      <= 0;
			cur_mode     <= PAT_BARS;
			cur_color    <= '0;
			n_hsync      <= 0;
			n_vsync      <= 0;
			n_front      <= 0;
			n_de_line    <= 0;
			n_frame_lines <= 0;
			pix_hits     <= '{default: 0};
		end else begin
			hs_prev      <= hs_on;
			vs_prev      <= vs_on;
			de_prev      <= o_de;
			rst_cnt      <= rst_cnt + 1;
			h_since_rise <= hs_rise ? 1 : h_since_rise + 1;
			v_since_rise <= vs_rise ? 1 : v_since_rise + 1;
			h_width      <= hs_on ? (hs_prev ? h_width + 1 : 1) : 0;
			v_width      <= vs_on ? (vs_prev ? v_width + 1 : 1) : 0;
			de_low_cnt   <= o_de ? 0 : de_low_cnt + 1;
			de_run       <= o_de ? (de_prev ? de_run + 1 : 1) : 0;
			if (hs_rise) h_rises <= h_rises + 1;
			if (vs_rise) v_rises <= v_rises + 1;
			if (o_de) begin
				line_had_de <= 1'b1;
				pix_hits[cur_mode] <= pix_hits[cur_mode] + 1;
			end else if (hs_rise) begin
				line_had_de <= 1'b0;
			end
			if (o_frame_start) begin
				de_lines    <= 0;
				frames_seen <= frames_seen + 1;
				fs_seen     <= 1'b1;
				cur_mode    <= pattern_mode_t'(i_mode); // mode and colour follow the new frame.
				cur_color   <= i_solid_color;
			end else if (de_rise) begin
				de_lines <= de_lines + 1;
			end
			if (hs_rise && h_rises != 0) n_hsync <= n_hsync + 1;
			if (vs_rise && v_rises != 0) n_vsync <= n_vsync + 1;
			if (hs_rise && line_had_de) n_front <= n_front + 1;
			if (de_fall) n_de_line <= n_de_line + 1;
			if (o_frame_start && frames_seen != 0) n_frame_lines <= n_frame_lines + 1;
		end
	end

	// checks sample on the falling edge between pin updates.
	a_reset_pins: assert property (@(negedge i_clock_out)
		(i_rst || !fs_seen) |-> ({o_de, hs_on, vs_on} == 3'b000))
		else value_fail("o_de,hsync,vsync active", 32'd0, 32'({o_de, hs_on, vs_on}));
	a_first_frame: assert property (@(negedge i_clock_out) disable iff (i_rst)
		(o_frame_start && !fs_seen) |-> (rst_cnt == 3))
		else value_fail("o_frame_start delay", 32'd3, rst_cnt);
	a_hsync_period: assert property (@(negedge i_clock_out) disable iff (i_rst)
		(hs_rise && h_rises != 0) |-> (h_since_rise == H_TOTAL))
		else value_fail("o_hsync period", H_TOTAL, h_since_rise);
	a_hsync_width: assert property (@(negedge i_clock_out) disable iff (i_rst)
		hs_fall |-> (h_width == DEF_H_PULSE))
		else value_fail("o_hsync width", DEF_H_PULSE, h_width);
	a_front_porch: assert property (@(negedge i_clock_out) disable iff (i_rst)
		(hs_rise && line_had_de) |-> (de_low_cnt == DEF_H_FRONT))
		else value_fail("o_hsync front porch", DEF_H_FRONT, de_low_cnt);
	a_vsync_period: assert property (@(negedge i_clock_out) disable iff (i_rst)
		(vs_rise && v_rises != 0) |-> (v_since_rise == FRAME_CYCLES))
		else value_fail("o_vsync period", FRAME_CYCLES, v_since_rise);
	a_vsync_width: assert property (@(negedge i_clock_out) disable iff (i_rst)
		vs_fall |-> (v_width == DEF_V_PULSE * H_TOTAL))
		else value_fail("o_vsync width", DEF_V_PULSE * H_TOTAL, v_width);
	a_de_per_line: assert property (@(negedge i_clock_out) disable iff (i_rst)
		de_fall |-> (de_run == DEF_H_ACTIVE))
		else value_fail("o_de cycles per line", DEF_H_ACTIVE, de_run);
	a_lines_per_frame: assert property (@(negedge i_clock_out) disable iff (i_rst)
		(o_frame_start && frames_seen != 0) |-> (de_lines == DEF_V_ACTIVE))
		else value_fail("o_de lines per frame", DEF_V_ACTIVE, de_lines);
	a_blank_black: assert property (@(negedge i_clock_out)
		!o_de |-> (pixel == 24'h000000))
		else value_fail("rgb in blanking", 32'd0, 32'(pixel));
	a_pixel_value: assert property (@(negedge i_clock_out) disable iff (i_rst)
		o_de |-> (pixel == exp_pix))
		else value_fail("rgb", 32'(exp_pix), 32'(pixel));

	task automatic wait_frame_start();
		do @(posedge i_clock_out); while (!o_frame_start);
	endtask

	task automatic wait_de_rises(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge i_clock_out);
			if (de_rise) seen++;
		end
	endtask

	// new inputs land halfway down the active lines.
	task automatic change_mid_frame(input logic [1:0] mode, input logic [23:0] color);
		wait_frame_start();
		wait_de_rises(DEF_V_ACTIVE / 2);
		#0.5;
		i_mode        = mode;
		i_solid_color = color;
	endtask

	task automatic finish_test(input string name, input int errs_before, input bit reached);
		@(negedge i_clock_out);
		if (!reached) begin
			tests_failed++;
			$display("test %s: its checks were never reached", name);
		end else if (fail_count != errs_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, fail_count - errs_before);
		end else begin
			tests_passed++;
			$display("test %s: passed", name);
		end
	endtask

	initial begin
		int          errs;
		int          chk_before;
		bit          old_kept;
		logic [23:0] color;
		lfsr_state    = 32'h2553;
		i_rst         = 1'b1;
		i_mode        = PAT_BARS;
		i_solid_color = 24'h000000;
		repeat (4) @(posedge i_clock_out);
		#0.5;
		i_rst = 1'b0;

		errs = fail_count;
		wait_frame_start();
		finish_test("reset_state", errs, 1'b1);

		errs = fail_count;
		repeat (3) wait_frame_start();
		finish_test("sync_timing", errs, n_hsync > 0 && n_vsync > 0 && n_front > 0);

		errs = fail_count;
		repeat (2) wait_frame_start();
		finish_test("active_region", errs, n_de_line > 0 && n_frame_lines > 0);

		errs = fail_count;
		change_mid_frame(PAT_CHECKER, i_solid_color);
		repeat (2) wait_frame_start();
		finish_test("bars_checker", errs,
			pix_hits[PAT_BARS] > 0 && pix_hits[PAT_CHECKER] > 0);

		errs = fail_count;
		change_mid_frame(PAT_RAMP, i_solid_color);
		chk_before = pix_hits[PAT_CHECKER];
		wait_frame_start();
		@(negedge i_clock_out);
		old_kept = pix_hits[PAT_CHECKER] > chk_before; // rest of frame stays checker.
		random_color(color);
		change_mid_frame(PAT_SOLID, color);
		repeat (2) wait_frame_start();
		random_color(color);
		change_mid_frame(PAT_SOLID, color);
		repeat (2) wait_frame_start();
		finish_test("ramp_solid_latch", errs,
			old_kept && pix_hits[PAT_RAMP] > 0 && pix_hits[PAT_SOLID] > 0);

		$display("tests passed %0d failed %0d, check errors %0d",
			tests_passed, tests_failed, fail_count);
		if (tests_failed == 0 && fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns before the tests completed", $time);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== video_out.f ====
hw/video_timing_pkg.sv
hw/video_pixel_pkg.sv
hw/video_sync_if.sv
hw/video_timing_gen.sv
hw/video_pattern_gen.sv
hw/video_output_stage.sv
hw/video_out_top.sv
dv/video_out_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the video_out testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f video_out.f --top-module video_out_tb -o video_out_sim

out=$(./obj_dir/video_out_sim)
echo "$out"

# the run passes only if the testbench printed its pass line.
echo "$out" | grep -q "^RESULT: PASS$"
